//--- design/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// ********************
// widths
// ********************
`define XLEN          32
`define TIMER_W       64
`define CSR_ADDR_W    12
// implemented low bits of mcause
`define CSR_ECODE_W   5

// ********************
// constant and reset values
// ********************
// rv32 with I, M, S and U extensions
`define CSR_MISA_VALUE   32'h4014_1100
`define CSR_HART_ID      32'h0000_0000
`define CSR_MTVEC_RESET  32'h0000_0100

// ********************
// csr addresses
// ********************
// machine info, read only
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14
// machine trap setup and handling
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
// supervisor
`define CSR_ADDR_SSCRATCH   12'h140
// machine counters
`define CSR_ADDR_MCYCLE     12'hB00
`define CSR_ADDR_MINSTRET   12'hB02
`define CSR_ADDR_MCYCLEH    12'hB80
`define CSR_ADDR_MINSTRETH  12'hB82
// user counter aliases
`define CSR_ADDR_CYCLE      12'hC00
`define CSR_ADDR_TIME       12'hC01
`define CSR_ADDR_INSTRET    12'hC02
`define CSR_ADDR_CYCLEH     12'hC80
`define CSR_ADDR_TIMEH      12'hC81
`define CSR_ADDR_INSTRETH   12'hC82

`endif

//--- design/csr_pkg.sv
`default_nettype none

`include "csr_config.svh"

package csr_pkg;

    // ********************
    // privilege levels
    // ********************
    // encoding matches bits [9:8] of a csr address
    typedef enum logic [1:0] {
        USER       = 2'b00,
        SUPERVISOR = 2'b01,
        MACHINE    = 2'b11
    } priv_t;

    // csr instruction operation, low bits of funct3
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    // ********************
    // csr address
    // ********************
    // rw_bits all ones marks a read-only register
    typedef struct packed {
        logic [1:0] rw_bits;
        priv_t      priv;
        logic [7:0] sub_addr;
    } csr_addr_fields_t;

    // same 12 bits, raw number or field view
    typedef union packed {
        logic [`CSR_ADDR_W-1:0] raw;
        csr_addr_fields_t       fields;
    } csr_addr_u;

endpackage

`default_nettype wire

//--- design/csr_counters.sv
`default_nettype none

`include "csr_config.svh"

module csr_counters import csr_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                retire,
    input  wire logic                retire_no_rd,
    output logic [`TIMER_W-1:0]      mcycle,
    output logic [`TIMER_W-1:0]      mtime,
    output logic [`TIMER_W-1:0]      minstret
);

    // retires seen last cycle as 0 to 2
    logic [1:0] retire_inc;

    // ********************
    // retire increment
    // ********************
    // both strobes give 2 and one gives 1
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_inc <= 2'd0;
        end else begin
            retire_inc <= {retire & retire_no_rd, retire ^ retire_no_rd};
        end
    end

    // ********************
    // counters
    // ********************
    // time runs off the core clock at the cycle rate
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            mtime <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;
            mtime <= mtime + 1'b1;
            minstret <= minstret + `TIMER_W'(retire_inc);
        end
    end

endmodule

`default_nettype wire

//--- design/csr_read_mux.sv
`default_nettype none

`include "csr_config.svh"

module csr_read_mux import csr_pkg::*; (
    input  wire csr_addr_u            csr_addr,
    input  wire logic [`XLEN-1:0]     mtvec,
    input  wire logic [`XLEN-1:0]     mepc,
    input  wire logic [`XLEN-1:0]     mcause,
    input  wire logic [`XLEN-1:0]     mscratch,
    input  wire logic [`XLEN-1:0]     sscratch,
    input  wire logic [`TIMER_W-1:0]  mcycle,
    input  wire logic [`TIMER_W-1:0]  mtime,
    input  wire logic [`TIMER_W-1:0]  minstret,
    output logic [`XLEN-1:0]          sel_value,
    output logic                      invalid_addr
);

    // ********************
    // full address decode
    // ********************
    always_comb begin
        sel_value = '0;
        invalid_addr = 1'b0;
        case (csr_addr.raw)
            // machine info, constants
            `CSR_ADDR_MISA:      sel_value = `CSR_MISA_VALUE;
            `CSR_ADDR_MVENDORID: sel_value = '0;
            `CSR_ADDR_MARCHID:   sel_value = '0;
            `CSR_ADDR_MIMPID:    sel_value = '0;
            `CSR_ADDR_MHARTID:   sel_value = `CSR_HART_ID;
            // machine trap setup and handling
            `CSR_ADDR_MTVEC:     sel_value = mtvec;
            `CSR_ADDR_MSCRATCH:  sel_value = mscratch;
            `CSR_ADDR_MEPC:      sel_value = mepc;
            `CSR_ADDR_MCAUSE:    sel_value = mcause;
            `CSR_ADDR_SSCRATCH:  sel_value = sscratch;
            // machine counters, low then high half
            `CSR_ADDR_MCYCLE:    sel_value = mcycle[`XLEN-1:0];
            `CSR_ADDR_MINSTRET:  sel_value = minstret[`XLEN-1:0];
            `CSR_ADDR_MCYCLEH:   sel_value = mcycle[`TIMER_W-1:`XLEN];
            `CSR_ADDR_MINSTRETH: sel_value = minstret[`TIMER_W-1:`XLEN];
            // user aliases of the same counters
            `CSR_ADDR_CYCLE:     sel_value = mcycle[`XLEN-1:0];
            `CSR_ADDR_TIME:      sel_value = mtime[`XLEN-1:0];
            `CSR_ADDR_INSTRET:   sel_value = minstret[`XLEN-1:0];
            `CSR_ADDR_CYCLEH:    sel_value = mcycle[`TIMER_W-1:`XLEN];
            `CSR_ADDR_TIMEH:     sel_value = mtime[`TIMER_W-1:`XLEN];
            `CSR_ADDR_INSTRETH:  sel_value = minstret[`TIMER_W-1:`XLEN];
            // not implemented
            default: begin
                sel_value = '0;
                invalid_addr = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/csr_regs.sv
`default_nettype none

`include "csr_config.svh"

module csr_regs import csr_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              write_en,
    input  wire csr_addr_u         csr_addr,
    input  wire csr_op_t           csr_op,
    input  wire logic [`XLEN-1:0]  rs1,
    input  wire logic [`XLEN-1:0]  sel_value,
    output logic [`XLEN-1:0]       mtvec,
    output logic [`XLEN-1:0]       mepc,
    output logic [`XLEN-1:0]       mcause,
    output logic [`XLEN-1:0]       mscratch,
    output logic [`XLEN-1:0]       sscratch
);

    // field views of the writable addresses
    localparam csr_addr_u MTVEC_A = `CSR_ADDR_MTVEC;
    localparam csr_addr_u MEPC_A = `CSR_ADDR_MEPC;
    localparam csr_addr_u MCAUSE_A = `CSR_ADDR_MCAUSE;
    localparam csr_addr_u MSCRATCH_A = `CSR_ADDR_MSCRATCH;
    localparam csr_addr_u SSCRATCH_A = `CSR_ADDR_SSCRATCH;

    logic [`XLEN-1:0]        new_value;
    logic [`CSR_ECODE_W-1:0] ecode;
    logic                    machine_write;
    logic                    supervisor_write;

    // ********************
    // update value
    // ********************
    always_comb begin
        case (csr_op)
            CSR_RS:  new_value = sel_value | rs1;
            CSR_RC:  new_value = sel_value & ~rs1;
            default: new_value = rs1;
        endcase
    end

    // sub_addr alone is ambiguous, mscratch and sscratch share it
    assign machine_write = write_en && (csr_addr.fields.priv == MACHINE);
    assign supervisor_write = write_en && (csr_addr.fields.priv == SUPERVISOR);

    // ********************
    // registers
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= `CSR_MTVEC_RESET;
            mepc <= '0;
            ecode <= '0;
            mscratch <= '0;
            sscratch <= '0;
        end else if (machine_write) begin
            case (csr_addr.fields.sub_addr)
                // vector and pc are word aligned
                MTVEC_A.fields.sub_addr:    mtvec <= {new_value[`XLEN-1:2], 2'b00};
                MEPC_A.fields.sub_addr:     mepc <= {new_value[`XLEN-1:2], 2'b00};
                MCAUSE_A.fields.sub_addr:   ecode <= new_value[`CSR_ECODE_W-1:0];
                MSCRATCH_A.fields.sub_addr: mscratch <= new_value;
                default: ;
            endcase
        end else if (supervisor_write) begin
            if (csr_addr.fields.sub_addr == SSCRATCH_A.fields.sub_addr) begin
                sscratch <= new_value;
            end
        end
    end

    // upper cause bits read as zero
    assign mcause = {{(`XLEN-`CSR_ECODE_W){1'b0}}, ecode};

endmodule

`default_nettype wire

//--- design/csr_ctrl.sv
`default_nettype none

`include "csr_config.svh"

module csr_ctrl import csr_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              request,
    input  wire csr_addr_u         csr_addr,
    input  wire priv_t             priv_level,
    input  wire logic              invalid_addr,
    input  wire logic [`XLEN-1:0]  sel_value,
    input  wire logic              accepted,
    output logic                   write_en,
    output logic                   ready,
    output logic                   done,
    output logic [`XLEN-1:0]       rd,
    output logic                   illegal
);

    logic priv_violation;
    logic illegal_access;
    logic read_only;

    // ********************
    // access check
    // ********************
    // address needs a higher level than the hart is running at
    assign priv_violation = (csr_addr.fields.priv > priv_level);
    assign illegal_access = invalid_addr | priv_violation;
    assign read_only = &csr_addr.fields.rw_bits;

    // write only in the request cycle, legal and writable
    assign write_en = request & ~illegal_access & ~read_only;

    // ********************
    // result slot
    // ********************
    // one item in flight, ready drops until the result is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= 1'b1;
            done <= 1'b0;
        end else if (request) begin
            ready <= 1'b0;
            done <= 1'b1;
        end else if (accepted && done) begin
            ready <= 1'b1;
            done <= 1'b0;
        end
    end

    // captured at the request edge, held while done
    always_ff @(posedge clk) begin
        if (request) begin
            rd <= illegal_access ? '0 : sel_value;
            illegal <= illegal_access;
        end
    end

endmodule

`default_nettype wire

//--- design/csr_unit.sv
`default_nettype none

`include "csr_config.svh"

module csr_unit import csr_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              request,
    input  wire csr_addr_u         csr_addr,
    input  wire csr_op_t           csr_op,
    input  wire logic [`XLEN-1:0]  rs1,
    input  wire priv_t             priv_level,
    input  wire logic              retire,
    input  wire logic              retire_no_rd,
    input  wire logic              accepted,
    output logic                   ready,
    output logic                   done,
    output logic [`XLEN-1:0]       rd,
    output logic                   illegal
);

    // ********************
    // internal nets
    // ********************
    logic                 invalid_addr;
    logic                 write_en;
    logic [`XLEN-1:0]     sel_value;
    logic [`XLEN-1:0]     mtvec;
    logic [`XLEN-1:0]     mepc;
    logic [`XLEN-1:0]     mcause;
    logic [`XLEN-1:0]     mscratch;
    logic [`XLEN-1:0]     sscratch;
    logic [`TIMER_W-1:0]  mcycle;
    logic [`TIMER_W-1:0]  mtime;
    logic [`TIMER_W-1:0]  minstret;

    // access check and result slot
    csr_ctrl csr_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .request      (request),
        .csr_addr     (csr_addr),
        .priv_level   (priv_level),
        .invalid_addr (invalid_addr),
        .sel_value    (sel_value),
        .accepted     (accepted),
        .write_en     (write_en),
        .ready        (ready),
        .done         (done),
        .rd           (rd),
        .illegal      (illegal)
    );

    // read value, also the old value for set and clear
    csr_read_mux csr_read_mux_inst (
        .csr_addr     (csr_addr),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .mcause       (mcause),
        .mscratch     (mscratch),
        .sscratch     (sscratch),
        .mcycle       (mcycle),
        .mtime        (mtime),
        .minstret     (minstret),
        .sel_value    (sel_value),
        .invalid_addr (invalid_addr)
    );

    csr_regs csr_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .write_en  (write_en),
        .csr_addr  (csr_addr),
        .csr_op    (csr_op),
        .rs1       (rs1),
        .sel_value (sel_value),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .mcause    (mcause),
        .mscratch  (mscratch),
        .sscratch  (sscratch)
    );

    csr_counters csr_counters_inst (
        .clk          (clk),
        .rst          (rst),
        .retire       (retire),
        .retire_no_rd (retire_no_rd),
        .mcycle       (mcycle),
        .mtime        (mtime),
        .minstret     (minstret)
    );

endmodule

`default_nettype wire

//--- tb/csr_unit_sva.sv
`default_nettype none

`include "csr_config.svh"

module csr_unit_sva (
    input wire logic             clk,
    input wire logic             rst,
    input wire logic             request,
    input wire logic             accepted,
    input wire logic             ready,
    input wire logic             done,
    input wire logic [`XLEN-1:0] rd
);

    int failures = 0;

    // ********************
    // result slot protocol
    // ********************
    // done only follows a request edge
    done_after_request: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(request))
    else begin
        failures++;
        $error("done rose without a request in the cycle before");
    end

    // slot is either free or full
    ready_xor_done: assert property (@(posedge clk) disable iff (rst) !(ready && done))
    else begin
        failures++;
        $error("ready and done high together");
    end

    // held result until taken
    rd_held: assert property (@(posedge clk) disable iff (rst)
        done && !accepted |=> $stable(rd))
    else begin
        failures++;
        $error("rd changed while done was high and accepted low");
    end

endmodule

`default_nettype wire

//--- tb/csr_unit_tb.sv
`default_nettype none

`include "csr_config.svh"

module csr_unit_tb import csr_pkg::*; ();

    localparam int RAND_DELAY_MAX = 8;
    localparam int RESET_CYCLES = 16;

    logic             clk;
    logic             rst;
    logic             request;
    csr_addr_u        csr_addr;
    csr_op_t          csr_op;
    logic [`XLEN-1:0] rs1;
    priv_t            priv_level;
    logic             retire = 1'b0;
    logic             retire_no_rd = 1'b0;
    logic             accepted;
    logic             ready;
    logic             done;
    logic [`XLEN-1:0] rd;
    logic             illegal;

    int value_errors;
    int run_errors;
    int watchdog_cycles;
    bit loaded;
    string vectors[$];

    // instret model with strobes sampled one and two edges back
    int unsigned retired_1 = 0;
    int unsigned retired_2 = 0;
    int unsigned instret_at_req = 0;

    csr_unit csr_unit_inst (.*);

    bind csr_unit csr_unit_sva csr_unit_sva_inst (
        .clk      (clk),
        .rst      (rst),
        .request  (request),
        .accepted (accepted),
        .ready    (ready),
        .done     (done),
        .rd       (rd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ********************
    // retire strobes
    // ********************
    always @(posedge clk) begin
        if (rst) begin
            retire <= 1'b0;
            retire_no_rd <= 1'b0;
        end else begin
            retire <= $urandom_range(1, 0) == 1;
            retire_no_rd <= $urandom_range(1, 0) == 1;
        end
    end

    // strobes sampled at edge e show up in a read at edge e+2
    always @(posedge clk) begin
        if (rst) begin
            retired_1 <= 0;
            retired_2 <= 0;
        end else begin
            if (request) begin
                instret_at_req <= retired_2;
            end
            retired_2 <= retired_1;
            retired_1 <= retired_1 + 32'(retire) + 32'(retire_no_rd);
        end
    end

    // ********************
    // compare tasks
    // ********************
    task automatic check_rd(input string name, input logic [`XLEN-1:0] exp,
            input logic [`XLEN-1:0] got);
        if (got !== exp) begin
            value_errors++;
            $display("Fail %s rd expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic check_illegal(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            value_errors++;
            $display("Fail %s illegal expected %b actual %b", name, exp, got);
        end
    endtask

    task automatic check_delta(input string name, input logic [`TIMER_W-1:0] exp,
            input logic [`TIMER_W-1:0] got);
        if (got !== exp) begin
            value_errors++;
            $display("Fail %s counter delta expected %0d actual %0d", name, exp, got);
        end
    endtask

    function automatic csr_op_t op_from_text(input string s);
        if (s == "rs") return CSR_RS;
        if (s == "rc") return CSR_RC;
        return CSR_RW;
    endfunction

    function automatic priv_t priv_from_text(input string s);
        if (s == "U") return USER;
        if (s == "S") return SUPERVISOR;
        return MACHINE;
    endfunction

    // ********************
    // one access through the result slot
    // ********************
    task automatic access(input csr_op_t op, input csr_addr_u addr,
            input logic [`XLEN-1:0] operand, input priv_t priv, input int hold,
            output logic [`XLEN-1:0] got_rd, output logic got_ill);
        int waited;
        request <= 1'b1;
        csr_op <= op;
        csr_addr <= addr;
        rs1 <= operand;
        priv_level <= priv;
        @(posedge clk);
        if (!ready) begin
            run_errors++;
            $display("request issued while ready was low");
        end
        request <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!done && waited < 20);
        if (!done) begin
            run_errors++;
            $display("done did not rise within 20 cycles of the request");
            return;
        end
        if (waited != 1) begin
            run_errors++;
            $display("done rose %0d cycles after the request instead of one", waited);
        end
        got_rd = rd;
        got_ill = illegal;
        // slot must hold under back-pressure
        repeat (hold) begin
            @(posedge clk);
            if (!done || ready || rd !== got_rd || illegal !== got_ill) begin
                run_errors++;
                $display("result slot did not hold while accepted was late");
            end
        end
        accepted <= 1'b1;
        @(posedge clk);
        accepted <= 1'b0;
    endtask

    task automatic run_vector(input string line);
        string name;
        string op_s;
        string priv_s;
        string delay_s;
        string exp_s;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`XLEN-1:0] operand;
        logic [`XLEN-1:0] rd_a;
        logic [`XLEN-1:0] rd_b;
        logic [`XLEN-1:0] seen;
        logic exp_ill;
        logic ill_a;
        logic ill_b;
        int unsigned retired_a;
        int hold;
        void'($sscanf(line, "%s %s %h %h %s %s %s %h", name, op_s, addr, operand,
            priv_s, delay_s, exp_s, exp_ill));
        if (delay_s == "random") begin
            hold = int'($urandom_range(RAND_DELAY_MAX, 1));
        end else begin
            hold = delay_s.atoi();
        end
        if (op_s != "cnt") begin
            access(op_from_text(op_s), addr, operand, priv_from_text(priv_s), hold,
                rd_a, ill_a);
            if (exp_s != "-") begin
                check_rd(name, exp_s.atohex(), rd_a);
            end
            check_illegal(name, exp_ill, ill_a);
        end else begin
            // two reads with request edges operand cycles apart
            access(CSR_RS, addr, '0, priv_from_text(priv_s), 0, rd_a, ill_a);
            retired_a = instret_at_req;
            repeat (operand - 3) @(posedge clk);
            access(CSR_RS, addr, '0, priv_from_text(priv_s), 0, rd_b, ill_b);
            check_illegal(name, exp_ill, ill_a | ill_b);
            seen = rd_b - rd_a;
            // instret and minstret sit at sub address 02
            if (addr[1:0] == 2'b10) begin
                check_delta(name, `TIMER_W'(instret_at_req - retired_a), `TIMER_W'(seen));
            end else begin
                check_delta(name, `TIMER_W'(exp_s.atohex()), `TIMER_W'(seen));
            end
        end
    endtask

    // ********************
    // main sequence
    // ********************
    initial begin
        int fd;
        int longest;
        int gap;
        string line;
        string name;
        string op_s;
        string priv_s;
        string delay_s;
        logic [`CSR_ADDR_W-1:0] addr;
        void'($urandom(32'h1857501c));
        rst = 1'b1;
        request = 1'b0;
        csr_addr = '0;
        csr_op = CSR_RW;
        rs1 = '0;
        priv_level = MACHINE;
        accepted = 1'b0;
        value_errors = 0;
        run_errors = 0;
        longest = RAND_DELAY_MAX;
        fd = $fopen("tb/csr_testdata.txt", "r");
        if (fd == 0) begin
            run_errors++;
            $display("cannot open tb/csr_testdata.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.getc(0) != "#" && $sscanf(line, "%s %s %h %h %s %s", name, op_s,
                        addr, gap, priv_s, delay_s) == 6) begin
                    vectors.push_back(line);
                    if (op_s == "cnt" && gap > longest) begin
                        longest = gap;
                    end
                    if (delay_s != "random" && delay_s.atoi() > longest) begin
                        longest = delay_s.atoi();
                    end
                end
            end
            $fclose(fd);
        end
        if (vectors.size() == 0) begin
            run_errors++;
            $display("no test vectors were read");
        end
        // each vector is at most two accesses plus its longest wait
        watchdog_cycles = vectors.size() * (longest + 8) + RESET_CYCLES + 100;
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        foreach (vectors[i]) begin
            run_vector(vectors[i]);
        end
        @(posedge clk);
        $display("%0d value errors, %0d run errors, %0d assertion failures",
            value_errors, run_errors, csr_unit_inst.csr_unit_sva_inst.failures);
        if (value_errors == 0 && run_errors == 0
                && csr_unit_inst.csr_unit_sva_inst.failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // ********************
    // watchdog
    // ********************
    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", watchdog_cycles);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/csr_testdata.txt
# name op(rw rs rc cnt) addr rs1 priv(U S M) accept_delay expected_rd expected_illegal
# cnt: rs1 is the gap in cycles between two reads, expected_rd the delta; - skips rd
rd_misa        rs  301 00000000 M 0      40141100 0
rd_mvendorid   rs  F11 00000000 M 1      00000000 0
rd_marchid     rs  F12 00000000 M 0      00000000 0
rd_mimpid      rs  F13 00000000 M random 00000000 0
rd_mhartid     rs  F14 00000000 M 2      00000000 0
rd_mtvec_rst   rs  305 00000000 M 0      00000100 0
wr_mscratch    rw  340 A5A5F00F M 0      00000000 0
rs_mscratch    rs  340 0000FF00 M random A5A5F00F 0
rc_mscratch    rc  340 A0000001 M random A5A5FF0F 0
rd_mscratch    rs  340 00000000 M 0      05A5FF0E 0
wr_sscratch    rw  140 12345678 S 0      00000000 0
rs_sscratch    rs  140 80000001 S 3      12345678 0
rd_sscratch    rs  140 00000000 M 0      92345679 0
wr_mtvec       rw  305 00002003 M 0      00000100 0
rs_mtvec       rs  305 00000013 M random 00002000 0
rd_mtvec       rs  305 00000000 M 0      00002010 0
wr_mepc        rw  341 80000006 M 0      00000000 0
rd_mepc        rs  341 00000000 M 8      80000004 0
wr_mcause      rw  342 FFFFFFFF M random 00000000 0
rc_mcause      rc  342 00000003 M 0      0000001F 0
rd_mcause      rs  342 00000000 M 0      0000001C 0
bad_addr       rw  7C0 FFFFFFFF M 0      00000000 1
mscratch_user  rw  340 FFFFFFFF U 0      00000000 1
mscratch_sup   rs  340 FFFFFFFF S random 00000000 1
rd_mscr_after  rs  340 00000000 M 0      05A5FF0E 0
wr_mhartid     rw  F14 FFFFFFFF M 0      00000000 0
rd_mhartid2    rs  F14 00000000 M random 00000000 0
wr_cycle       rw  C00 FFFFFFFF M 0      -        0
wr_cycleh      rw  C80 FFFFFFFF U 0      00000000 0
cnt_mcycle     cnt B00 00000007 M 0      00000007 0
cnt_cycle_long cnt C00 00000064 U 0      00000064 0
cnt_time       cnt C01 00000011 U 0      00000011 0
cnt_minstret   cnt B02 00000020 M 0      -        0
cnt_instret    cnt C02 00000009 U 0      -        0
rd_after_bp    rs  140 00000000 S random 92345679 0

//--- project.f
+incdir+design
design/csr_pkg.sv
design/csr_counters.sv
design/csr_read_mux.sv
design/csr_regs.sv
design/csr_ctrl.sv
design/csr_unit.sv
tb/csr_unit_sva.sv
tb/csr_unit_tb.sv

//--- Makefile
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module csr_unit_tb \
		-Mdir $(OBJ_DIR) -o csr_unit_tb

run: compile
	$(OBJ_DIR)/csr_unit_tb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
